// ==== list.f ====
div_pkg.sv
div_apb_regs.sv
div_ctrl_fsm.sv
div_iter_counter.sv
div_sign_unit.sv
div_radix4_core.sv
div_top.sv
div_assert.sv
tb_div_top.sv

// ==== Bender.yml ====
package:
  name: radix4_divider

sources:
  - files:
      - div_pkg.sv
      - div_apb_regs.sv
      - div_ctrl_fsm.sv
      - div_iter_counter.sv
      - div_sign_unit.sv
      - div_radix4_core.sv
      - div_top.sv
  - target: test
    files:
      - div_assert.sv
      - tb_div_top.sv

// ==== tb_div_top.sv ====
// testbench of the APB radix-4 divider
// writes operands, starts divisions, polls STATUS and compares quotient,
// remainder and dz with a reference model
`default_nettype none

module tb_div_top;

	import div_pkg::*;

	localparam int W = 32;
	localparam logic [W-1:0] MIN_NEG = {1'b1, {(W-1){1'b0}}};

	logic                  clk;
	logic                  rst_n;
	logic [APB_ADDR_W-1:0] paddr;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [W-1:0]          pwdata;
	logic [W-1:0]          prdata;
	logic                  pready;
	logic                  pslverr;

	integer seed;
	int     errors;
	int     checks;
	int     test_err;

	div_top #(.WIDTH(W)) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.paddr_i(paddr),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ========================================================================
	// bus and checking helpers
	// ========================================================================
	task automatic abort_run(input string why);
		$display("%0t: %s", $time, why);
		$display("Errors found");
		$finish;
	endtask

	// one APB transfer, inputs change on the falling edge
	task automatic apb_xfer(input logic [APB_ADDR_W-1:0] addr, input logic wr,
		input logic [W-1:0] wdata, output logic [W-1:0] rdata, output logic err);
		int waits;
		@(negedge clk);
		paddr   = addr;
		pwrite  = wr;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waits   = 0;
		// transfer completes on the rising edge that sees pready
		@(posedge clk);
		while (!pready && waits < 8) begin
			@(posedge clk);
			waits++;
		end
		if (!pready) begin
			abort_run("APB transfer stalled with pready low");
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic check_eq(input string name, input logic [W-1:0] exp, input logic [W-1:0] got);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %0t %s expected %h actual %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// truncating division, remainder keeps the dividend sign
	function automatic void model_div(input logic [W-1:0] a, input logic [W-1:0] b,
		input logic sgn, output logic [W-1:0] q, output logic [W-1:0] r);
		longint sa;
		longint sb;
		sa = $signed(a);
		sb = $signed(b);
		if (b == '0) begin
			q = '1;
			r = a;
		end else if (sgn && a == MIN_NEG && b == '1) begin
			q = a;
			r = '0;
		end else if (sgn) begin
			q = W'(sa / sb);
			r = W'(sa % sb);
		end else begin
			q = a / b;
			r = a % b;
		end
	endfunction

	task automatic start_div(input logic [W-1:0] a, input logic [W-1:0] b, input logic sgn);
		logic [W-1:0] ctrl;
		logic [W-1:0] rd;
		logic         err;
		ctrl = '0;
		ctrl[CTRL_START_BIT]  = 1'b1;
		ctrl[CTRL_SIGNED_BIT] = sgn;
		apb_xfer(ADDR_DIVIDEND, 1'b1, a, rd, err);
		apb_xfer(ADDR_DIVISOR, 1'b1, b, rd, err);
		apb_xfer(ADDR_CTRL, 1'b1, ctrl, rd, err);
	endtask

	// poll STATUS for done, then read and check the results
	task automatic finish_check(input logic [W-1:0] a, input logic [W-1:0] b, input logic sgn);
		logic [W-1:0] status;
		logic [W-1:0] q;
		logic [W-1:0] r;
		logic [W-1:0] exp_q;
		logic [W-1:0] exp_r;
		logic         err;
		int           polls;
		status = '0;
		polls  = 0;
		while (!status[STAT_DONE_BIT] && polls < 40) begin
			apb_xfer(ADDR_STATUS, 1'b0, '0, status, err);
			polls++;
		end
		if (!status[STAT_DONE_BIT]) begin
			abort_run("division did not finish within 40 STATUS polls");
		end
		apb_xfer(ADDR_QUOTIENT, 1'b0, '0, q, err);
		apb_xfer(ADDR_REMAINDER, 1'b0, '0, r, err);
		model_div(a, b, sgn, exp_q, exp_r);
		check_eq("quotient", exp_q, q);
		check_eq("remainder", exp_r, r);
		check_eq("status dz", W'(b == '0), W'(status[STAT_DZ_BIT]));
	endtask

	task automatic divide_and_check(input logic [W-1:0] a, input logic [W-1:0] b,
		input logic sgn);
		start_div(a, b, sgn);
		finish_check(a, b, sgn);
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_err);
		test_err = errors;
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================
	initial begin
		logic [W-1:0] a;
		logic [W-1:0] b;
		logic [W-1:0] rd;
		logic         err;
		seed     = 32'hc4d959a6;
		errors   = 0;
		checks   = 0;
		test_err = 0;
		rst_n    = 1'b0;
		paddr    = '0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		pwdata   = '0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < 200; i++) begin
			a = $random(seed);
			b = $random(seed);
			// shorter divisors give long quotients
			b = b >> (i % W);
			divide_and_check(a, b, 1'b0);
		end
		end_test(1, "random unsigned");

		divide_and_check(W'(100), W'(7), 1'b1);
		divide_and_check(W'(-100), W'(7), 1'b1);
		divide_and_check(W'(100), W'(-7), 1'b1);
		divide_and_check(W'(-100), W'(-7), 1'b1);
		divide_and_check(MIN_NEG, W'(3), 1'b1);
		divide_and_check(MIN_NEG, '1, 1'b1);
		end_test(2, "signed combinations");

		divide_and_check(W'(1234), '0, 1'b0);
		divide_and_check(W'(-1234), '0, 1'b1);
		// dz must clear again
		divide_and_check(W'(50), W'(6), 1'b0);
		end_test(3, "divide by zero");

		divide_and_check(W'(5), W'(9), 1'b0);
		divide_and_check(W'(-5), W'(9), 1'b1);
		divide_and_check('0, W'(13), 1'b0);
		divide_and_check('0, W'(-13), 1'b1);
		end_test(4, "small and zero dividend");

		apb_xfer(8'h20, 1'b0, '0, rd, err);
		check_eq("pslverr", W'(1), W'(err));
		apb_xfer(8'h1c, 1'b1, W'(7), rd, err);
		check_eq("pslverr", W'(1), W'(err));
		// second start and new dividend land while the first run is busy
		start_div(32'hffff_fff0, W'(7), 1'b0);
		apb_xfer(ADDR_STATUS, 1'b0, '0, rd, err);
		check_eq("status busy", W'(1), W'(rd[STAT_BUSY_BIT]));
		apb_xfer(ADDR_DIVIDEND, 1'b1, W'(99), rd, err);
		apb_xfer(ADDR_CTRL, 1'b1, W'(3), rd, err);
		finish_check(32'hffff_fff0, W'(7), 1'b0);
		// the operand register itself still took the write
		apb_xfer(ADDR_DIVIDEND, 1'b0, '0, rd, err);
		check_eq("dividend", W'(99), rd);
		end_test(5, "pslverr and start while busy");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== div_assert.sv ====
// protocol and timing checks of the APB divider
// bound into div_top, watches the APB access phase, the busy and done
// flags, the start-to-done latency and the state sequencing
`default_nettype none

module div_assert #(
	parameter int WIDTH = 32
) (
	input logic                clk,
	input logic                rst_n,
	input logic                psel_i,
	input logic                penable_i,
	input logic                pready_i,
	input logic                start_i,
	input logic                busy_i,
	input logic                done_i,
	input div_pkg::div_state_e state_i
);

	import div_pkg::*;

	// prepare, WIDTH/2 digits at most, fix, then done shows
	localparam int MAX_LAT = WIDTH / 2 + 3;

	// zero wait states
	a_pready: assert property (@(posedge clk) disable iff (!rst_n)
		(psel_i && penable_i) |-> pready_i)
		else $error("pready low in an APB access phase");

	a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
		!(busy_i && done_i))
		else $error("busy and done high together");

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start_i |-> ##[1:MAX_LAT] done_i)
		else $error("done missing after start");

	// idle and done only leave on a start
	a_no_start: assert property (@(posedge clk) disable iff (!rst_n)
		((state_i == ST_IDLE || state_i == ST_DONE) && !start_i) |=> $stable(state_i))
		else $error("state left idle or done without a start");

endmodule

bind div_top div_assert #(.WIDTH(WIDTH)) u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.psel_i(psel_i),
	.penable_i(penable_i),
	.pready_i(pready_o),
	.start_i(start),
	.busy_i(busy),
	.done_i(done),
	.state_i(state)
);

`default_nettype wire

// ==== div_top.sv ====
// radix-4 integer divider behind an APB slave
// software writes operands, starts a signed or unsigned division and
// polls STATUS; quotient, remainder and divide-by-zero flag are then
// readable until the next start
`default_nettype none

module div_top #(
	parameter int WIDTH = div_pkg::DIV_WIDTH
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [div_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic                           psel_i,
	input  logic                           penable_i,
	input  logic                           pwrite_i,
	input  logic [WIDTH-1:0]               pwdata_i,
	output logic [WIDTH-1:0]               prdata_o,
	output logic                           pready_o,
	output logic                           pslverr_o
);

	import div_pkg::*;

	div_state_e             state;
	logic                   busy;
	logic                   done;
	logic                   start;
	logic                   signed_op;
	logic                   last;
	logic                   zero_iter;
	logic                   div_zero;
	logic [$clog2(WIDTH)-1:0] skip_pairs;
	logic [WIDTH-1:0]       dividend;
	logic [WIDTH-1:0]       divisor;
	logic [WIDTH-1:0]       dividend_abs;
	logic [WIDTH-1:0]       divisor_abs;
	logic [WIDTH-1:0]       quot_raw;
	logic [WIDTH-1:0]       rem_raw;
	logic [WIDTH-1:0]       quotient;
	logic [WIDTH-1:0]       remainder;

	// ======================================================================
	// bus side and control
	// ======================================================================
	div_apb_regs #(.WIDTH(WIDTH)) u_regs (
		.clk(clk), .rst_n(rst_n),
		.paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i),
		.pwrite_i(pwrite_i), .pwdata_i(pwdata_i),
		.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
		.busy_i(busy), .done_i(done), .div_zero_i(div_zero),
		.quotient_i(quotient), .remainder_i(remainder),
		.start_o(start), .signed_op_o(signed_op),
		.dividend_o(dividend), .divisor_o(divisor)
	);

	div_ctrl_fsm #(.WIDTH(WIDTH)) u_fsm (
		.clk(clk), .rst_n(rst_n),
		.start_i(start), .last_i(last), .zero_iter_i(zero_iter),
		.state_o(state), .busy_o(busy), .done_o(done)
	);

	div_iter_counter #(.WIDTH(WIDTH)) u_cnt (
		.clk(clk), .rst_n(rst_n),
		.state_i(state), .dividend_abs_i(dividend_abs), .div_zero_i(div_zero),
		.last_o(last), .zero_iter_o(zero_iter), .skip_pairs_o(skip_pairs)
	);

	// ======================================================================
	// datapath
	// ======================================================================
	div_sign_unit #(.WIDTH(WIDTH)) u_sign (
		.clk(clk), .rst_n(rst_n),
		.start_i(start), .state_i(state), .signed_op_i(signed_op),
		.dividend_i(dividend), .divisor_i(divisor),
		.quot_raw_i(quot_raw), .rem_raw_i(rem_raw),
		.dividend_abs_o(dividend_abs), .divisor_abs_o(divisor_abs),
		.div_zero_o(div_zero), .quotient_o(quotient), .remainder_o(remainder)
	);

	div_radix4_core #(.WIDTH(WIDTH)) u_core (
		.clk(clk), .rst_n(rst_n),
		.state_i(state), .dividend_abs_i(dividend_abs), .divisor_abs_i(divisor_abs),
		.div_zero_i(div_zero), .skip_pairs_i(skip_pairs),
		.quot_raw_o(quot_raw), .rem_raw_o(rem_raw)
	);

endmodule

`default_nettype wire

// ==== div_radix4_core.sv ====
// radix-4 restoring digit recurrence
// each ITER cycle brings two dividend bits into four times the partial
// remainder, picks the largest multiple 0..3 of the divisor that fits,
// subtracts it and shifts that digit into the quotient
`default_nettype none

module div_radix4_core #(
	parameter int WIDTH = 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  div_pkg::div_state_e      state_i,
	input  logic [WIDTH-1:0]         dividend_abs_i,
	input  logic [WIDTH-1:0]         divisor_abs_i,
	input  logic                     div_zero_i,
	input  logic [$clog2(WIDTH)-1:0] skip_pairs_i,
	output logic [WIDTH-1:0]         quot_raw_o,
	output logic [WIDTH-1:0]         rem_raw_o
);

	import div_pkg::*;

	// two extra bits hold four times a remainder below the divisor
	localparam int EXT_W = WIDTH + 2;

	logic [WIDTH-1:0] dvd_q;
	logic [WIDTH-1:0] rem_q;
	logic [WIDTH-1:0] quot_q;
	logic [EXT_W-1:0] rem_x4;
	logic [EXT_W-1:0] d1;
	logic [EXT_W-1:0] d2;
	logic [EXT_W-1:0] d3;
	logic [EXT_W-1:0] rem_nxt;
	logic [1:0]       digit;

	// ======================================================================
	// digit selection
	// ======================================================================
	assign rem_x4 = {rem_q, dvd_q[WIDTH-1 -: 2]};
	assign d1     = EXT_W'(divisor_abs_i);
	assign d2     = d1 << 1;
	assign d3     = d1 + d2;

	always_comb begin
		if (rem_x4 >= d3) begin
			digit   = 2'd3;
			rem_nxt = rem_x4 - d3;
		end else if (rem_x4 >= d2) begin
			digit   = 2'd2;
			rem_nxt = rem_x4 - d2;
		end else if (rem_x4 >= d1) begin
			digit   = 2'd1;
			rem_nxt = rem_x4 - d1;
		end else begin
			digit   = 2'd0;
			rem_nxt = rem_x4;
		end
	end

	// empty leading pairs are shifted out before the first digit
	always_ff @(posedge clk) begin
		if (state_i == ST_PREP) begin
			dvd_q <= dividend_abs_i << {skip_pairs_i, 1'b0};
		end else if (state_i == ST_ITER) begin
			dvd_q <= dvd_q << 2;
		end
	end

	// zero divisor result is preloaded, ITER is skipped for it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rem_q  <= '0;
			quot_q <= '0;
		end else if (state_i == ST_PREP) begin
			rem_q  <= div_zero_i ? dividend_abs_i : '0;
			quot_q <= div_zero_i ? '1 : '0;
		end else if (state_i == ST_ITER) begin
			rem_q  <= rem_nxt[WIDTH-1:0];
			quot_q <= {quot_q[WIDTH-3:0], digit};
		end
	end

	assign quot_raw_o = quot_q;
	assign rem_raw_o  = rem_q;

endmodule

`default_nettype wire

// ==== div_sign_unit.sv ====
// sign handling of the divider
// captures operand signs and magnitudes on start, then applies the
// signs to the raw quotient and remainder in FIX
`default_nettype none

module div_sign_unit #(
	parameter int WIDTH = 32
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start_i,
	input  div_pkg::div_state_e state_i,
	input  logic                signed_op_i,
	input  logic [WIDTH-1:0]    dividend_i,
	input  logic [WIDTH-1:0]    divisor_i,
	input  logic [WIDTH-1:0]    quot_raw_i,
	input  logic [WIDTH-1:0]    rem_raw_i,
	output logic [WIDTH-1:0]    dividend_abs_o,
	output logic [WIDTH-1:0]    divisor_abs_o,
	output logic                div_zero_o,
	output logic [WIDTH-1:0]    quotient_o,
	output logic [WIDTH-1:0]    remainder_o
);

	import div_pkg::*;

	logic dvd_sign;
	logic dvs_sign;
	logic dvd_neg_q;
	logic dvs_neg_q;
	logic div_zero_q;
	logic quot_neg;

	// unsigned mode never sees a negative operand
	assign dvd_sign = signed_op_i & dividend_i[WIDTH-1];
	assign dvs_sign = signed_op_i & divisor_i[WIDTH-1];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dvd_neg_q  <= 1'b0;
			dvs_neg_q  <= 1'b0;
			div_zero_q <= 1'b0;
		end else if (start_i) begin
			dvd_neg_q  <= dvd_sign;
			dvs_neg_q  <= dvs_sign;
			div_zero_q <= (divisor_i == '0);
		end
	end

	// most negative value keeps its bit pattern as magnitude 2**(WIDTH-1)
	always_ff @(posedge clk) begin
		if (start_i) begin
			dividend_abs_o <= dvd_sign ? -dividend_i : dividend_i;
			divisor_abs_o  <= dvs_sign ? -divisor_i : divisor_i;
		end
	end

	// all-ones quotient of a zero divisor stays unsigned
	assign quot_neg = (dvd_neg_q ^ dvs_neg_q) & ~div_zero_q;

	// remainder follows the dividend sign
	always_ff @(posedge clk) begin
		if (state_i == ST_FIX) begin
			quotient_o  <= quot_neg ? -quot_raw_i : quot_raw_i;
			remainder_o <= dvd_neg_q ? -rem_raw_i : rem_raw_i;
		end
	end

	assign div_zero_o = div_zero_q;

endmodule

`default_nettype wire

// ==== div_iter_counter.sv ====
// iteration control of the divider
// leading-zero count of the absolute dividend gives the empty digit pairs
// to skip; the remaining pairs are counted down during the recurrence
`default_nettype none

module div_iter_counter #(
	parameter int WIDTH = 32
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  div_pkg::div_state_e        state_i,
	input  logic [WIDTH-1:0]           dividend_abs_i,
	input  logic                       div_zero_i,
	output logic                       last_o,
	output logic                       zero_iter_o,
	output logic [$clog2(WIDTH)-1:0]   skip_pairs_o
);

	import div_pkg::*;

	localparam int LZC_W = $clog2(WIDTH + 1);
	localparam int CNT_W = $clog2(WIDTH);

	logic [LZC_W-1:0] lzc;
	logic [CNT_W-1:0] n_iter;
	logic [CNT_W-1:0] cnt_q;

	// highest set bit wins, all zeros gives WIDTH
	function automatic logic [LZC_W-1:0] count_lz(input logic [WIDTH-1:0] v);
		logic [LZC_W-1:0] n;
		n = LZC_W'(WIDTH);
		for (int i = 0; i < WIDTH; i++) begin
			if (v[i]) begin
				n = LZC_W'(WIDTH - 1 - i);
			end
		end
		return n;
	endfunction

	assign lzc          = count_lz(dividend_abs_i);
	assign skip_pairs_o = CNT_W'(lzc >> 1);

	// one digit per remaining pair, none at all for a zero divisor
	assign n_iter      = div_zero_i ? '0 : CNT_W'(WIDTH / 2) - skip_pairs_o;
	assign zero_iter_o = (n_iter == '0);

	// ======================================================================
	// countdown, loaded in PREP
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (state_i == ST_PREP) begin
			cnt_q <= n_iter;
		end else if (state_i == ST_ITER) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign last_o = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

// ==== div_ctrl_fsm.sv ====
// divider sequencer
// steps through prepare, digit iterations and sign fix, then holds done
// until software issues the next start
`default_nettype none

module div_ctrl_fsm #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start_i,
	input  logic               last_i,
	input  logic               zero_iter_i,
	output div_pkg::div_state_e state_o,
	output logic               busy_o,
	output logic               done_o
);

	import div_pkg::*;

	div_state_e state_q;
	div_state_e state_d;

	// ======================================================================
	// next state
	// ======================================================================
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE, ST_DONE: begin
				if (start_i) begin
					state_d = ST_PREP;
				end
			end
			// nothing to iterate for a zero divisor or a zero dividend
			ST_PREP: state_d = zero_iter_i ? ST_FIX : ST_ITER;
			ST_ITER: begin
				if (last_i) begin
					state_d = ST_FIX;
				end
			end
			ST_FIX:  state_d = ST_DONE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign state_o = state_q;
	assign busy_o  = (state_q == ST_PREP) | (state_q == ST_ITER) | (state_q == ST_FIX);
	assign done_o  = (state_q == ST_DONE);

endmodule

`default_nettype wire

// ==== div_apb_regs.sv ====
// APB slave register file of the divider
// holds dividend, divisor and the signed flag, issues the start pulse,
// and returns status and results with zero wait states
// unmapped addresses complete with pslverr
`default_nettype none

module div_apb_regs #(
	parameter int WIDTH = 32
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [div_pkg::APB_ADDR_W-1:0] paddr_i,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [WIDTH-1:0]              pwdata_i,
	output logic [WIDTH-1:0]              prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	input  logic                          busy_i,
	input  logic                          done_i,
	input  logic                          div_zero_i,
	input  logic [WIDTH-1:0]              quotient_i,
	input  logic [WIDTH-1:0]              remainder_i,
	output logic                          start_o,
	output logic                          signed_op_o,
	output logic [WIDTH-1:0]              dividend_o,
	output logic [WIDTH-1:0]              divisor_o
);

	import div_pkg::*;

	logic             access;
	logic             wr_en;
	logic             mapped;
	logic             signed_q;
	logic [WIDTH-1:0] dividend_q;
	logic [WIDTH-1:0] divisor_q;
	logic [WIDTH-1:0] status_word;
	logic [WIDTH-1:0] ctrl_word;
	logic [WIDTH-1:0] rdata;

	// access phase of a transfer, never stretched
	assign access   = psel_i & penable_i;
	assign wr_en    = access & pwrite_i & mapped;
	assign pready_o = 1'b1;

	// start only completes when the divider is idle or done
	assign start_o = wr_en & (paddr_i == ADDR_CTRL) & pwdata_i[CTRL_START_BIT] & ~busy_i;

	// the written mode bit goes straight to the sign unit with the pulse
	assign signed_op_o = start_o ? pwdata_i[CTRL_SIGNED_BIT] : signed_q;

	// ======================================================================
	// writable registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			signed_q <= 1'b0;
		end else if (start_o) begin
			signed_q <= pwdata_i[CTRL_SIGNED_BIT];
		end
	end

	// operands may change during a run, the sign unit holds its own copy
	always_ff @(posedge clk) begin
		if (wr_en && paddr_i == ADDR_DIVIDEND) begin
			dividend_q <= pwdata_i;
		end
		if (wr_en && paddr_i == ADDR_DIVISOR) begin
			divisor_q <= pwdata_i;
		end
	end

	assign dividend_o = dividend_q;
	assign divisor_o  = divisor_q;

	// ======================================================================
	// read path
	// ======================================================================
	always_comb begin
		status_word = '0;
		status_word[STAT_BUSY_BIT] = busy_i;
		status_word[STAT_DONE_BIT] = done_i;
		status_word[STAT_DZ_BIT]   = div_zero_i;
		// start bit always reads back as zero
		ctrl_word = '0;
		ctrl_word[CTRL_SIGNED_BIT] = signed_q;
	end

	always_comb begin
		mapped = 1'b1;
		rdata  = '0;
		case (paddr_i)
			ADDR_DIVIDEND:  rdata = dividend_q;
			ADDR_DIVISOR:   rdata = divisor_q;
			ADDR_CTRL:      rdata = ctrl_word;
			ADDR_STATUS:    rdata = status_word;
			ADDR_QUOTIENT:  rdata = quotient_i;
			ADDR_REMAINDER: rdata = remainder_i;
			default:        mapped = 1'b0;
		endcase
	end

	assign prdata_o  = rdata;
	// error response for any hole in the map
	assign pslverr_o = access & ~mapped;

endmodule

`default_nettype wire

// ==== div_pkg.sv ====
// radix-4 divider shared definitions
// operand width default, APB register map, status and control bit
// positions, and the controller state encoding
`default_nettype none

package div_pkg;

	// default operand width, top level passes it down as WIDTH
	localparam int unsigned DIV_WIDTH = 32;

	// APB address width
	localparam int unsigned APB_ADDR_W = 8;

	// ======================================================================
	// register map
	// ======================================================================
	localparam logic [APB_ADDR_W-1:0] ADDR_DIVIDEND  = 8'h00;
	localparam logic [APB_ADDR_W-1:0] ADDR_DIVISOR   = 8'h04;
	localparam logic [APB_ADDR_W-1:0] ADDR_CTRL      = 8'h08;
	localparam logic [APB_ADDR_W-1:0] ADDR_STATUS    = 8'h0C;
	localparam logic [APB_ADDR_W-1:0] ADDR_QUOTIENT  = 8'h10;
	localparam logic [APB_ADDR_W-1:0] ADDR_REMAINDER = 8'h14;

	// CTRL and STATUS bit positions
	localparam int unsigned CTRL_START_BIT  = 0;
	localparam int unsigned CTRL_SIGNED_BIT = 1;
	localparam int unsigned STAT_BUSY_BIT   = 0;
	localparam int unsigned STAT_DONE_BIT   = 1;
	localparam int unsigned STAT_DZ_BIT     = 2;

	// controller states
	typedef enum logic [2:0] {
		ST_IDLE = 3'd0,
		ST_PREP = 3'd1,
		ST_ITER = 3'd2,
		ST_FIX  = 3'd3,
		ST_DONE = 3'd4
	} div_state_e;

endpackage

`default_nettype wire
